// File: verilog/motorPkg.sv
package motorPkg;

    // step period input in prescaled units
    typedef logic [9:0] freqT;

    // commutation step index 0 to 5
    typedef logic [2:0] stepT;

    // command for one half bridge
    typedef logic [1:0] legCmdT;

    typedef enum logic [1:0] {
        MODE_COAST,
        MODE_BRAKE,
        MODE_RUN
    } motorModeT;

    // leg commands
    localparam legCmdT LEG_OFF  = 2'd0;
    localparam legCmdT LEG_HIGH = 2'd1;
    localparam legCmdT LEG_LOW  = 2'd2;

    // shortest step period accepted
    localparam freqT FREQ_MIN = 10'd1000;

    // clocks per period unit
    localparam int STEP_PRESCALE = 10;

    // clocks with both switches of a leg off after a command change
    localparam int DEAD_CYCLES = 8;

    // pwm carrier
    localparam int PWM_PERIOD = 100;
    localparam int PWM_DUTY   = 75;

endpackage

// File: verilog/pwmGen.sv
module pwmGen (
    input  logic clk,
    input  logic nRst,
    output logic pwm
);

    import motorPkg::*;

    localparam int CW = $clog2(PWM_PERIOD);
    localparam logic [CW-1:0] CNT_LAST = CW'(PWM_PERIOD - 1);
    localparam logic [CW-1:0] CNT_DUTY = CW'(PWM_DUTY);

    logic [CW-1:0] carrier;

    // free-running carrier, no sync to the step timer
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            carrier <= '0;
        end else if (carrier == CNT_LAST) begin
            carrier <= '0;
        end else begin
            carrier <= carrier + 1'b1;
        end
    end

    // on for the first duty clocks of each period
    assign pwm = (carrier < CNT_DUTY);

endmodule

// File: verilog/stepTimer.sv
module stepTimer (
    input  logic          clk,
    input  logic          nRst,
    input  logic          run,
    input  motorPkg::freqT freq,
    output logic          stepPulse
);

    import motorPkg::*;

    localparam int PW = $clog2(STEP_PRESCALE);
    localparam logic [PW-1:0] PRE_LAST = PW'(STEP_PRESCALE - 1);

    logic [PW-1:0] preCnt;
    freqT          unitCnt;
    freqT          periodReg;
    logic          preWrap;
    logic          stepEnd;

    assign preWrap   = (preCnt == PRE_LAST);
    assign stepEnd   = preWrap && (unitCnt == periodReg - 1'b1);
    assign stepPulse = run && stepEnd;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            preCnt    <= '0;
            unitCnt   <= '0;
            periodReg <= FREQ_MIN;
        end else if (!run) begin
            // parked, next step starts from zero with a fresh period
            preCnt    <= '0;
            unitCnt   <= '0;
            periodReg <= freq;
        end else if (preWrap) begin
            preCnt <= '0;
            if (stepEnd) begin
                unitCnt   <= '0;
                periodReg <= freq;
            end else begin
                unitCnt <= unitCnt + 1'b1;
            end
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

    // counters restart on run rise, so no pulse in the first run cycle
    aPulseOnlyRunning: assert property (@(posedge clk) disable iff (!nRst)
        stepPulse |-> run && $past(run))
        else $error("step pulse without a running motor");

endmodule

// File: verilog/commutator.sv
module commutator (
    input  logic             clk,
    input  logic             nRst,
    input  logic             start,
    input  logic             inv,
    input  logic             stepPulse,
    output motorPkg::legCmdT legCmdA,
    output motorPkg::legCmdT legCmdB,
    output motorPkg::legCmdT legCmdC,
    output logic             run
);

    import motorPkg::*;

    motorModeT mode;
    motorModeT nextMode;
    stepT      step;
    stepT      stepFwd;
    stepT      stepRev;

    always_comb begin
        if (start) begin
            nextMode = MODE_RUN;
        end else if (inv) begin
            nextMode = MODE_BRAKE;
        end else begin
            nextMode = MODE_COAST;
        end
    end

    // modulo-6 neighbours
    assign stepFwd = (step == 3'd5) ? 3'd0 : step + 3'd1;
    assign stepRev = (step == 3'd0) ? 3'd5 : step - 3'd1;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            mode <= MODE_COAST;
            step <= '0;
        end else begin
            mode <= nextMode;
            if (nextMode == MODE_RUN && mode != MODE_RUN) begin
                step <= '0;
            end else if (mode == MODE_RUN && stepPulse) begin
                step <= inv ? stepRev : stepFwd;
            end
        end
    end

    assign run = (mode == MODE_RUN);

    // step table with one phase high, one low and the third floating
    always_comb begin
        legCmdA = LEG_OFF;
        legCmdB = LEG_OFF;
        legCmdC = LEG_OFF;
        case (mode)
            MODE_BRAKE: begin
                legCmdA = LEG_LOW;
                legCmdB = LEG_LOW;
                legCmdC = LEG_LOW;
            end
            MODE_RUN: begin
                case (step)
                    3'd0: begin
                        legCmdA = LEG_HIGH;
                        legCmdB = LEG_LOW;
                    end
                    3'd1: begin
                        legCmdA = LEG_HIGH;
                        legCmdC = LEG_LOW;
                    end
                    3'd2: begin
                        legCmdB = LEG_HIGH;
                        legCmdC = LEG_LOW;
                    end
                    3'd3: begin
                        legCmdB = LEG_HIGH;
                        legCmdA = LEG_LOW;
                    end
                    3'd4: begin
                        legCmdC = LEG_HIGH;
                        legCmdA = LEG_LOW;
                    end
                    3'd5: begin
                        legCmdC = LEG_HIGH;
                        legCmdB = LEG_LOW;
                    end
                    default: begin
                        legCmdA = LEG_OFF;
                    end
                endcase
            end
            default: begin
                legCmdA = LEG_OFF;
            end
        endcase
    end

    aStepRange: assert property (@(posedge clk) disable iff (!nRst)
        step < 3'd6)
        else $error("step index out of range");

endmodule

// File: verilog/deadTime.sv
module deadTime (
    input  logic             clk,
    input  logic             nRst,
    input  motorPkg::legCmdT legCmd,
    output logic             gateH,
    output logic             gateL
);

    import motorPkg::*;

    localparam int DW = $clog2(DEAD_CYCLES + 1);
    localparam logic [DW-1:0] DEAD_LOAD = DW'(DEAD_CYCLES - 1);

    legCmdT        lastCmd;
    logic [DW-1:0] deadCnt;
    logic          cmdChange;

    assign cmdChange = (legCmd != lastCmd);

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            lastCmd <= LEG_OFF;
            deadCnt <= '0;
            gateH   <= 1'b0;
            gateL   <= 1'b0;
        end else if (cmdChange) begin
            // new command, open both switches and restart the gap
            lastCmd <= legCmd;
            deadCnt <= DEAD_LOAD;
            gateH   <= 1'b0;
            gateL   <= 1'b0;
        end else if (deadCnt != '0) begin
            deadCnt <= deadCnt - 1'b1;
            gateH   <= 1'b0;
            gateL   <= 1'b0;
        end else begin
            gateH <= (lastCmd == LEG_HIGH);
            gateL <= (lastCmd == LEG_LOW);
        end
    end

    aNoShootThrough: assert property (@(posedge clk) disable iff (!nRst)
        !(gateH && gateL))
        else $error("both switches of a leg on");

    // full gap after every command change
    aDeadGap: assert property (@(posedge clk) disable iff (!nRst)
        cmdChange |=> (!gateH && !gateL) [*DEAD_CYCLES])
        else $error("dead interval cut short");

endmodule

// File: verilog/motor3Core.sv
module motor3Core (
    input  logic          clk,
    input  logic          nRst,
    input  logic          start,
    input  logic          inv,
    input  motorPkg::freqT freq,
    output logic          aHi,
    output logic          aLi,
    output logic          bHi,
    output logic          bLi,
    output logic          cHi,
    output logic          cLi
);

    import motorPkg::*;

    logic   run;
    logic   stepPulse;
    logic   pwm;
    legCmdT legCmdA;
    legCmdT legCmdB;
    legCmdT legCmdC;
    logic   gateHA;
    logic   gateLA;
    logic   gateHB;
    logic   gateLB;
    logic   gateHC;
    logic   gateLC;

    stepTimer u_stepTimer (
        .clk       (clk),
        .nRst      (nRst),
        .run       (run),
        .freq      (freq),
        .stepPulse (stepPulse)
    );

    commutator u_commutator (
        .clk       (clk),
        .nRst      (nRst),
        .start     (start),
        .inv       (inv),
        .stepPulse (stepPulse),
        .legCmdA   (legCmdA),
        .legCmdB   (legCmdB),
        .legCmdC   (legCmdC),
        .run       (run)
    );

    pwmGen u_pwm (
        .clk  (clk),
        .nRst (nRst),
        .pwm  (pwm)
    );

    deadTime u_legA (.clk(clk), .nRst(nRst), .legCmd(legCmdA), .gateH(gateHA), .gateL(gateLA));
    deadTime u_legB (.clk(clk), .nRst(nRst), .legCmd(legCmdB), .gateH(gateHB), .gateL(gateLB));
    deadTime u_legC (.clk(clk), .nRst(nRst), .legCmd(legCmdC), .gateH(gateHC), .gateL(gateLC));

    // only high sides are chopped, low sides stay solid
    assign aHi = gateHA & pwm;
    assign bHi = gateHB & pwm;
    assign cHi = gateHC & pwm;
    assign aLi = gateLA;
    assign bLi = gateLB;
    assign cLi = gateLC;

endmodule

// File: verilog/motor3Top.sv
module motor3Top (
    input  logic          clk,
    input  logic          nRst,
    input  logic          m3start,
    input  logic          m3invOrStop,
    input  motorPkg::freqT m3freq,
    output logic          aH,
    output logic          aL,
    output logic          bH,
    output logic          bL,
    output logic          cH,
    output logic          cL
);

    import motorPkg::*;

    logic startReg;
    logic invReg;
    freqT freqReg;

    logic aHi;
    logic aLi;
    logic bHi;
    logic bLi;
    logic cHi;
    logic cLi;

    // command inputs with the period clamped to the fastest allowed step
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            startReg <= 1'b0;
            invReg   <= 1'b0;
            freqReg  <= FREQ_MIN;
        end else begin
            startReg <= m3start;
            invReg   <= m3invOrStop;
            if (m3freq > FREQ_MIN) begin
                freqReg <= m3freq;
            end else begin
                freqReg <= FREQ_MIN;
            end
        end
    end

    motor3Core u_core (
        .clk   (clk),
        .nRst  (nRst),
        .start (startReg),
        .inv   (invReg),
        .freq  (freqReg),
        .aHi   (aHi),
        .aLi   (aLi),
        .bHi   (bHi),
        .bLi   (bLi),
        .cHi   (cHi),
        .cLi   (cLi)
    );

    // gate pins straight from flops
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            aH <= 1'b0;
            aL <= 1'b0;
            bH <= 1'b0;
            bL <= 1'b0;
            cH <= 1'b0;
            cL <= 1'b0;
        end else begin
            aH <= aHi;
            aL <= aLi;
            bH <= bHi;
            bL <= bLi;
            cH <= cHi;
            cL <= cLi;
        end
    end

    aFreqClamped: assert property (@(posedge clk) disable iff (!nRst)
        freqReg >= FREQ_MIN)
        else $error("step period below minimum reached the core");

endmodule

// File: verif/motor3Tb.sv
module motor3Tb;

    import motorPkg::*;

    // worst case about six slow steps per period test
    localparam int STEP_CLKS_MAX  = 1023 * STEP_PRESCALE;
    localparam int TEST_STEPS     = 13 + 7 + 4 * 6 + 4;
    localparam int TIMEOUT_CYCLES = TEST_STEPS * STEP_CLKS_MAX;
    // a chopped high leg only counts as off after a gap longer than pwm off time
    localparam int HIGH_HOLD = PWM_PERIOD - PWM_DUTY;

    logic clk;
    logic nRst;
    logic m3start;
    logic m3invOrStop;
    freqT m3freq;
    logic aH;
    logic aL;
    logic bH;
    logic bL;
    logic cH;
    logic cL;

    logic [2:0] hiPins;
    logic [2:0] loPins;
    logic [2:0] loPrev;
    legCmdT     legState [3];
    int         offCnt [3];
    int         lastSide [3];
    int         gapCnt [3];
    int         hiRun [3];
    int         nHigh;
    int         nLow;
    logic [5:0] curPat;
    logic [5:0] lastPat;
    logic [5:0] patQ [$];
    int         lowRiseQ [$];

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int monChecks = 0;
    int monErrors = 0;
    int sideFlips = 0;
    int highPulses = 0;
    int seed;

    motor3Top i_dut (
        .clk         (clk),
        .nRst        (nRst),
        .m3start     (m3start),
        .m3invOrStop (m3invOrStop),
        .m3freq      (m3freq),
        .aH          (aH),
        .aL          (aL),
        .bH          (bH),
        .bL          (bL),
        .cH          (cH),
        .cL          (cL)
    );

    // index 0 is phase A
    assign hiPins = {cH, bH, aH};
    assign loPins = {cL, bL, aL};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic stepT nextStep(stepT s, logic inv);
        int v;
        // stepping back by one is stepping forward by five
        v = int'(s) + (inv ? 5 : 1);
        return stepT'(v % 6);
    endfunction

    // gate bits aH aL bH bL cH cL with high sides unchopped
    function automatic logic [5:0] expectedPattern(stepT s, motorModeT mode);
        logic [5:0] gates;
        int         highPh;
        int         lowPh;
        gates = 6'b0;
        if (mode == MODE_BRAKE) begin
            gates = 6'b010101;
        end else if (mode == MODE_RUN) begin
            // high phase moves on even steps, low phase on odd steps
            highPh = int'(s) / 2;
            lowPh  = ((int'(s) + 1) / 2 + 1) % 3;
            gates[5 - 2 * highPh] = 1'b1;
            gates[4 - 2 * lowPh]  = 1'b1;
        end
        return gates;
    endfunction

    function automatic legCmdT legFromGates(logic h, logic l);
        if (h) begin
            return LEG_HIGH;
        end else if (l) begin
            return LEG_LOW;
        end
        return LEG_OFF;
    endfunction

    task automatic reportError(string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic reportMonitorError(string msg);
        monErrors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic checkGate(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            reportError($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic checkPattern(string what, legCmdT gotA, legCmdT gotB, legCmdT gotC,
                                logic [5:0] expGates);
        legCmdT expA;
        legCmdT expB;
        legCmdT expC;
        expA = legFromGates(expGates[5], expGates[4]);
        expB = legFromGates(expGates[3], expGates[2]);
        expC = legFromGates(expGates[1], expGates[0]);
        checks++;
        if ({gotA, gotB, gotC} !== {expA, expB, expC}) begin
            reportError($sformatf("%s legs %0d %0d %0d, expected %0d %0d %0d",
                what, gotA, gotB, gotC, expA, expB, expC));
        end
    endtask

    task automatic checkPeriod(string what, int measured, freqT reqFreq);
        freqT eff;
        int   expClks;
        eff = (reqFreq > FREQ_MIN) ? reqFreq : FREQ_MIN;
        // low sides rise every second step
        expClks = 2 * int'(eff) * STEP_PRESCALE;
        checks++;
        if (measured != expClks) begin
            reportError($sformatf("%s measured %0d clocks, expected %0d",
                what, measured, expClks));
        end
    endtask

    task automatic checkAllGates(string what, logic [5:0] exp);
        checkGate({what, " aH"}, aH, exp[5]);
        checkGate({what, " aL"}, aL, exp[4]);
        checkGate({what, " bH"}, bH, exp[3]);
        checkGate({what, " bL"}, bL, exp[2]);
        checkGate({what, " cH"}, cH, exp[1]);
        checkGate({what, " cL"}, cL, exp[0]);
    endtask

    task automatic checkRecorded(int idx, stepT s, string what);
        logic [5:0] pat;
        pat = patQ[idx];
        checkPattern($sformatf("%s pattern %0d", what, idx), pat[5:4], pat[3:2], pat[1:0],
            expectedPattern(s, MODE_RUN));
    endtask

    task automatic nextDriveSlot();
        @(posedge clk);
        #1;
    endtask

    task automatic waitPatterns(int n);
        while (patQ.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic waitLowRises(int n);
        while (lowRiseQ.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic waitGates(logic [5:0] exp, int limit);
        int n;
        n = 0;
        while ({aH, aL, bH, bL, cH, cL} !== exp && n < limit) begin
            nextDriveSlot();
            n++;
        end
    endtask

    task automatic finishTest(string name, int errStart);
        if (errors == errStart) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errStart);
        end
    endtask

    // leg states from the pins, with shoot-through, dead gap and pulse length checks
    always @(negedge clk) begin
        if (!nRst) begin
            for (int i = 0; i < 3; i++) begin
                legState[i] = LEG_OFF;
                offCnt[i]   = 0;
                lastSide[i] = 0;
                gapCnt[i]   = 0;
                hiRun[i]    = 0;
            end
            loPrev  = 3'b0;
            lastPat = 6'b0;
        end else begin
            nHigh = 0;
            nLow  = 0;
            for (int i = 0; i < 3; i++) begin
                monChecks++;
                if (hiPins[i] && loPins[i]) begin
                    reportMonitorError($sformatf("leg %0d has both switches on", i));
                end
                if (hiPins[i]) begin
                    if (lastSide[i] == 2) begin
                        sideFlips++;
                        if (gapCnt[i] < DEAD_CYCLES) begin
                            reportMonitorError($sformatf("leg %0d dead gap %0d clocks",
                                i, gapCnt[i]));
                        end
                    end
                    if (hiRun[i] == 0) begin
                        highPulses++;
                    end
                    hiRun[i]++;
                    if (hiRun[i] == PWM_DUTY + 1) begin
                        reportMonitorError($sformatf("leg %0d high pulse too long", i));
                    end
                    lastSide[i] = 1;
                    gapCnt[i]   = 0;
                    offCnt[i]   = 0;
                    legState[i] = LEG_HIGH;
                end else if (loPins[i]) begin
                    if (lastSide[i] == 1) begin
                        sideFlips++;
                        if (gapCnt[i] < DEAD_CYCLES) begin
                            reportMonitorError($sformatf("leg %0d dead gap %0d clocks",
                                i, gapCnt[i]));
                        end
                    end
                    if (!loPrev[i]) begin
                        lowRiseQ.push_back(cycles);
                    end
                    hiRun[i]    = 0;
                    lastSide[i] = 2;
                    gapCnt[i]   = 0;
                    offCnt[i]   = 0;
                    legState[i] = LEG_LOW;
                end else begin
                    hiRun[i] = 0;
                    gapCnt[i]++;
                    offCnt[i]++;
                    if (legState[i] == LEG_LOW || offCnt[i] > HIGH_HOLD) begin
                        legState[i] = LEG_OFF;
                    end
                end
                if (legState[i] == LEG_HIGH) begin
                    nHigh++;
                end else if (legState[i] == LEG_LOW) begin
                    nLow++;
                end
            end
            loPrev = loPins;
            curPat = {legState[0], legState[1], legState[2]};
            // only complete run patterns count, transitions in between are skipped
            if (nHigh == 1 && nLow == 1 && curPat != lastPat) begin
                patQ.push_back(curPat);
                lastPat = curPat;
            end
        end
    end

    initial begin
        freqT       freqList [4];
        logic [5:0] expGates;
        stepT       curStep;
        int         errStart;
        int         base;
        int         randVal;

        seed        = 32'hd7de02bb;
        nRst        = 1'b0;
        m3start     = 1'b0;
        m3invOrStop = 1'b0;
        m3freq      = FREQ_MIN;

        errStart = errors;
        repeat (2) @(posedge clk);
        #1;
        checkAllGates("in reset", 6'b0);
        repeat (3) @(posedge clk);
        #1;
        nRst = 1'b1;
        repeat (50) begin
            nextDriveSlot();
            checkAllGates("coast after reset", expectedPattern(3'd0, MODE_COAST));
        end
        finishTest("reset and coast", errStart);

        errStart = errors;
        nextDriveSlot();
        m3start = 1'b1;
        waitPatterns(13);
        curStep = 3'd0;
        checkRecorded(0, curStep, "forward");
        for (int i = 1; i < 13; i++) begin
            curStep = nextStep(curStep, 1'b0);
            checkRecorded(i, curStep, "forward");
        end
        finishTest("forward sequence", errStart);

        // direction flips mid step, takes effect at the next step
        errStart = errors;
        nextDriveSlot();
        m3invOrStop = 1'b1;
        waitPatterns(19);
        for (int i = 13; i < 19; i++) begin
            curStep = nextStep(curStep, 1'b1);
            checkRecorded(i, curStep, "reverse");
        end
        finishTest("reverse", errStart);

        errStart = errors;
        nextDriveSlot();
        m3start  = 1'b0;
        expGates = expectedPattern(3'd0, MODE_BRAKE);
        waitGates(expGates, 4 * DEAD_CYCLES);
        checkAllGates("brake", expGates);
        nextDriveSlot();
        m3invOrStop = 1'b0;
        expGates    = expectedPattern(3'd0, MODE_COAST);
        waitGates(expGates, 4 * DEAD_CYCLES);
        checkAllGates("coast", expGates);
        finishTest("brake and coast", errStart);

        errStart    = errors;
        freqList[0] = 10'd500;
        freqList[1] = 10'd1020;
        for (int i = 2; i < 4; i++) begin
            randVal     = $random(seed);
            freqList[i] = randVal[9:0];
        end
        nextDriveSlot();
        m3start = 1'b1;
        for (int i = 0; i < 4; i++) begin
            // change the period just after a low-side rise, far from a step boundary
            base = lowRiseQ.size();
            waitLowRises(base + 1);
            nextDriveSlot();
            m3freq = freqList[i];
            waitLowRises(base + 3);
            checkPeriod($sformatf("step period for m3freq %0d", freqList[i]),
                lowRiseQ[base + 2] - lowRiseQ[base + 1], freqList[i]);
        end
        finishTest("period clamp", errStart);

        errStart = errors;
        if (sideFlips == 0) begin
            reportError("no leg ever switched between its high and low side");
        end
        if (highPulses == 0) begin
            reportError("no high-side pulse was ever seen");
        end
        $display("test dead time and shoot-through: %0d side changes, %0d errors",
            sideFlips, monErrors + errors - errStart);

        $display("%0d checks, %0d errors", checks + monChecks, errors + monErrors);
        if (errors + monErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: motor3.f
verilog/motorPkg.sv
verilog/pwmGen.sv
verilog/stepTimer.sv
verilog/commutator.sv
verilog/deadTime.sv
verilog/motor3Core.sv
verilog/motor3Top.sv
verif/motor3Tb.sv

// File: Makefile
TOP := motor3Tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f motor3.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
